/* nr_sync_pkg.sv */
`default_nettype none

package nr_sync_pkg;

    // length of the SSS and of both m-sequences
    localparam int SSS_LEN = 127;

    // m-sequence generators, x0 uses taps 0 and 4, x1 uses taps 0 and 1
    localparam int MSEQ_ORDER = 7;
    localparam logic [MSEQ_ORDER-1:0] X0_TAPS = 7'h11;
    localparam logic [MSEQ_ORDER-1:0] X1_TAPS = 7'h03;

    // x(0) = 1, x(1..6) = 0 for both sequences
    localparam logic [MSEQ_ORDER-1:0] MSEQ_SEED = 7'd1;

    // cyclic shift rules
    // m0 = 15 * floor(N_id_1 / 112) + 5 * N_id_2
    // m1 = N_id_1 mod 112
    localparam int M1_PERIOD = 112;
    localparam int M0_STEP_GROUP = 15;
    localparam int M0_STEP_NID2 = 5;

    // identity ranges
    localparam int N_ID_1_COUNT = 336;
    localparam int N_ID_2_W = 2;
    localparam int N_ID_1_W = 9;
    localparam int N_ID_W = 10;

    // index into a length-127 sequence
    localparam int IDX_W = 7;

endpackage

`default_nettype wire

/* sss_types_pkg.sv */
`default_nettype none

package sss_types_pkg;

    import nr_sync_pkg::*;

    // one captured SSS with the sector it belongs to
    typedef struct packed {
        logic [SSS_LEN-1:0] bits;
        logic [N_ID_2_W-1:0] n_id_2;
    } sss_frame_t;

    // best hypothesis of a search
    // peak is the correlation magnitude, at most 127
    typedef struct packed {
        logic [N_ID_1_W-1:0] n_id_1;
        logic [N_ID_2_W-1:0] n_id_2;
        logic [IDX_W:0] peak;
    } sss_best_t;

endpackage

`default_nettype wire

/* mseq_lfsr.sv */
`timescale 1ns/10ps
`default_nettype none

module mseq_lfsr #(
    parameter logic [nr_sync_pkg::MSEQ_ORDER-1:0] TAPS = nr_sync_pkg::X0_TAPS,
    parameter logic [nr_sync_pkg::MSEQ_ORDER-1:0] SEED = nr_sync_pkg::MSEQ_SEED
) (
    input  logic clk_i,
    input  logic reset_ni,
    output logic bit_o,
    output logic valid_o
);

    import nr_sync_pkg::*;

    // state_q[k] holds x(i+k), bit 0 is the current output
    logic [MSEQ_ORDER-1:0] state_q;
    logic [IDX_W-1:0] count_q;
    logic feedback;

    // x(i+7) is the parity of the tapped stages
    assign feedback = ^(state_q & TAPS);

    assign bit_o = state_q[0];

    // one full period, then the generator stops
    assign valid_o = (count_q != IDX_W'(SSS_LEN));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= SEED;
            count_q <= '0;
        end else if (valid_o) begin
            state_q <= {feedback, state_q[MSEQ_ORDER-1:1]};
            count_q <= count_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* sss_capture.sv */
`timescale 1ns/10ps
`default_nettype none

module sss_capture (
    input  logic clk_i,
    input  logic reset_ni,
    input  logic sss_bit_i,
    input  logic sss_bit_valid_i,
    input  logic [nr_sync_pkg::N_ID_2_W-1:0] n_id_2_i,
    input  logic n_id_2_valid_i,
    input  logic busy_i,
    output sss_types_pkg::sss_frame_t frame_o,
    output logic frame_valid_o
);

    import nr_sync_pkg::*;

    logic [IDX_W-1:0] bit_idx_q;
    logic idle;
    logic take_bit;
    logic last_bit;

    // frame_o must stay stable while the correlator reads it,
    // so the input is also closed during the pulse cycle
    assign idle = !busy_i && !frame_valid_o;

    assign take_bit = idle && sss_bit_valid_i;
    assign last_bit = (bit_idx_q == IDX_W'(SSS_LEN - 1));

    // bit index and frame strobe
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            bit_idx_q <= '0;
            frame_valid_o <= 1'b0;
        end else begin
            frame_valid_o <= 1'b0;
            if (take_bit) begin
                if (last_bit) begin
                    bit_idx_q <= '0;
                    frame_valid_o <= 1'b1;
                end else begin
                    bit_idx_q <= bit_idx_q + 1'b1;
                end
            end
        end
    end

    // frame storage
    always_ff @(posedge clk_i) begin
        if (take_bit) begin
            frame_o.bits[bit_idx_q] <= sss_bit_i;
        end
        // sector from the PSS stage, only taken between searches
        if (idle && n_id_2_valid_i) begin
            frame_o.n_id_2 <= n_id_2_i;
        end
    end

endmodule

`default_nettype wire

/* sss_correlator.sv */
`timescale 1ns/10ps
`default_nettype none

module sss_correlator #(
    parameter int N_ID_1_SEARCH = nr_sync_pkg::N_ID_1_COUNT
) (
    input  logic clk_i,
    input  logic reset_ni,
    input  sss_types_pkg::sss_frame_t frame_i,
    input  logic frame_valid_i,
    output sss_types_pkg::sss_best_t best_o,
    output logic done_o,
    output logic busy_o
);

    import nr_sync_pkg::*;

    localparam int ACC_W = IDX_W + 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_ACC,
        S_CMP
    } state_e;

    // a + b mod 127, both operands already below 127
    function automatic logic [IDX_W-1:0] wrap_add(input logic [IDX_W-1:0] a,
                                                  input logic [IDX_W-1:0] b);
        logic [IDX_W:0] sum;
        sum = a + b;
        if (sum >= (IDX_W + 1)'(SSS_LEN)) begin
            sum = sum - (IDX_W + 1)'(SSS_LEN);
        end
        return sum[IDX_W-1:0];
    endfunction

    state_e state_q;
    logic x0_bit, x0_vld;
    logic x1_bit, x1_vld;
    logic [SSS_LEN-1:0] x0_tab, x1_tab;
    logic [IDX_W-1:0] fill_idx_q;
    logic tab_full;
    logic [IDX_W-1:0] k_q;
    logic [IDX_W-1:0] m0_q, m1_q;
    logic [IDX_W-1:0] pos0_q, pos1_q;
    logic [N_ID_1_W-1:0] n_id_1_q;
    logic signed [ACC_W-1:0] acc_q;
    logic [ACC_W-1:0] acc_abs;
    logic [IDX_W-1:0] m0_start, m0_next, m1_next;
    logic last_in_group;
    logic last_hyp;
    logic chip_pos;
    logic agree;

    mseq_lfsr #(
        .TAPS(X0_TAPS),
        .SEED(MSEQ_SEED)
    ) u_x0 (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .bit_o(x0_bit),
        .valid_o(x0_vld)
    );

    mseq_lfsr #(
        .TAPS(X1_TAPS),
        .SEED(MSEQ_SEED)
    ) u_x1 (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .bit_o(x1_bit),
        .valid_o(x1_vld)
    );

    // sequence tables, filled once after reset
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            fill_idx_q <= '0;
        end else if (x0_vld && x1_vld) begin
            fill_idx_q <= fill_idx_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (x0_vld && x1_vld) begin
            x0_tab[fill_idx_q] <= x0_bit;
            x1_tab[fill_idx_q] <= x1_bit;
        end
    end

    assign tab_full = (fill_idx_q == IDX_W'(SSS_LEN));

    // shift of the first hypothesis, 5 * N_id_2 by shifted adds
    always_comb begin
        m0_start = '0;
        for (int b = 0; b < N_ID_2_W; b++) begin
            if (frame_i.n_id_2[b]) begin
                m0_start = wrap_add(m0_start, IDX_W'(M0_STEP_NID2 << b));
            end
        end
    end

    // shifts of the following hypothesis
    assign last_in_group = (m1_q == IDX_W'(M1_PERIOD - 1));
    assign m1_next = last_in_group ? '0 : m1_q + 1'b1;
    assign m0_next = last_in_group ? wrap_add(m0_q, IDX_W'(M0_STEP_GROUP)) : m0_q;
    assign last_hyp = (n_id_1_q == N_ID_1_W'(N_ID_1_SEARCH - 1));

    // d = (1 - 2 x0) (1 - 2 x1) is +1 when both bits match
    assign chip_pos = ~(x0_tab[pos0_q] ^ x1_tab[pos1_q]);
    assign agree = (frame_i.bits[k_q] == chip_pos);

    assign acc_abs = acc_q[ACC_W-1] ? unsigned'(-acc_q) : unsigned'(acc_q);

    assign busy_o = (state_q != S_IDLE);

    // search control
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= S_IDLE;
            done_o <= 1'b0;
            k_q <= '0;
            n_id_1_q <= '0;
            m0_q <= '0;
            m1_q <= '0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (frame_valid_i) begin
                        state_q <= S_WAIT;
                        k_q <= '0;
                        n_id_1_q <= '0;
                        m0_q <= m0_start;
                        m1_q <= '0;
                    end
                end
                S_WAIT: begin
                    if (tab_full) begin
                        state_q <= S_ACC;
                    end
                end
                S_ACC: begin
                    if (k_q == IDX_W'(SSS_LEN - 1)) begin
                        k_q <= '0;
                        state_q <= S_CMP;
                    end else begin
                        k_q <= k_q + 1'b1;
                    end
                end
                S_CMP: begin
                    if (last_hyp) begin
                        done_o <= 1'b1;
                        state_q <= S_IDLE;
                    end else begin
                        n_id_1_q <= n_id_1_q + 1'b1;
                        m0_q <= m0_next;
                        m1_q <= m1_next;
                        state_q <= S_ACC;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // correlation datapath
    always_ff @(posedge clk_i) begin
        case (state_q)
            S_IDLE: begin
                if (frame_valid_i) begin
                    pos0_q <= m0_start;
                    pos1_q <= '0;
                    acc_q <= '0;
                    best_o.n_id_1 <= '0;
                    best_o.n_id_2 <= frame_i.n_id_2;
                    best_o.peak <= '0;
                end
            end
            S_ACC: begin
                acc_q <= agree ? acc_q + ACC_W'(1) : acc_q - ACC_W'(1);
                pos0_q <= wrap_add(pos0_q, IDX_W'(1));
                pos1_q <= wrap_add(pos1_q, IDX_W'(1));
            end
            S_CMP: begin
                // strict compare keeps the first of equal peaks
                if (acc_abs > best_o.peak) begin
                    best_o.peak <= acc_abs;
                    best_o.n_id_1 <= n_id_1_q;
                end
                acc_q <= '0;
                pos0_q <= m0_next;
                pos1_q <= m1_next;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* nid_report.sv */
`timescale 1ns/10ps
`default_nettype none

module nid_report (
    input  logic clk_i,
    input  logic reset_ni,
    input  sss_types_pkg::sss_best_t best_i,
    input  logic done_i,
    output logic [nr_sync_pkg::N_ID_1_W-1:0] n_id_1_o,
    output logic [nr_sync_pkg::N_ID_W-1:0] n_id_o,
    output logic n_id_valid_o
);

    import nr_sync_pkg::*;

    logic [N_ID_W-1:0] n_id_1_ext;
    logic [N_ID_W-1:0] n_id_calc;

    assign n_id_1_ext = N_ID_W'(best_i.n_id_1);

    // N_id = 3 * N_id_1 + N_id_2, at most 1007
    assign n_id_calc = (n_id_1_ext << 1) + n_id_1_ext + N_ID_W'(best_i.n_id_2);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            n_id_valid_o <= 1'b0;
            n_id_1_o <= '0;
            n_id_o <= '0;
        end else begin
            n_id_valid_o <= done_i;
            // results hold until the next search ends
            if (done_i) begin
                n_id_1_o <= best_i.n_id_1;
                n_id_o <= n_id_calc;
            end
        end
    end

endmodule

`default_nettype wire

/* sss_detector.sv */
`timescale 1ns/10ps
`default_nettype none

module sss_detector #(
    parameter int N_ID_1_SEARCH = nr_sync_pkg::N_ID_1_COUNT
) (
    input  logic clk_i,
    input  logic reset_ni,
    input  logic sss_bit_i,
    input  logic sss_bit_valid_i,
    input  logic [nr_sync_pkg::N_ID_2_W-1:0] n_id_2_i,
    input  logic n_id_2_valid_i,
    output logic [nr_sync_pkg::N_ID_1_W-1:0] n_id_1_o,
    output logic [nr_sync_pkg::N_ID_W-1:0] n_id_o,
    output logic n_id_valid_o
);

    import sss_types_pkg::*;

    sss_frame_t frame;
    logic frame_valid;
    logic busy;
    sss_best_t best;
    logic done;

    sss_capture u_capture (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .sss_bit_i(sss_bit_i),
        .sss_bit_valid_i(sss_bit_valid_i),
        .n_id_2_i(n_id_2_i),
        .n_id_2_valid_i(n_id_2_valid_i),
        .busy_i(busy),
        .frame_o(frame),
        .frame_valid_o(frame_valid)
    );

    sss_correlator #(
        .N_ID_1_SEARCH(N_ID_1_SEARCH)
    ) u_correlator (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .frame_i(frame),
        .frame_valid_i(frame_valid),
        .best_o(best),
        .done_o(done),
        .busy_o(busy)
    );

    nid_report u_report (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .best_i(best),
        .done_i(done),
        .n_id_1_o(n_id_1_o),
        .n_id_o(n_id_o),
        .n_id_valid_o(n_id_valid_o)
    );

endmodule

`default_nettype wire

/* sss_detector_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module sss_detector_assert #(
    parameter int N_ID_1_SEARCH = nr_sync_pkg::N_ID_1_COUNT
) (
    input logic clk_i,
    input logic reset_ni,
    input sss_types_pkg::sss_best_t best_i,
    input logic [nr_sync_pkg::N_ID_1_W-1:0] n_id_1_i,
    input logic [nr_sync_pkg::N_ID_W-1:0] n_id_i,
    input logic n_id_valid_i
);

    import nr_sync_pkg::*;

    logic [N_ID_W-1:0] n_id_sum;

    // sector of the winning search, held in best_i until the next frame
    assign n_id_sum = N_ID_W'(3) * N_ID_W'(n_id_1_i) + N_ID_W'(best_i.n_id_2);

    valid_single_pulse: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        n_id_valid_i |=> !n_id_valid_i
    ) else $error("n_id_valid_o high for more than one cycle");

    valid_low_in_reset: assert property (
        @(posedge clk_i)
        !reset_ni |=> !n_id_valid_i
    ) else $error("n_id_valid_o high after a reset cycle");

    n_id_matches_parts: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        n_id_valid_i |-> (n_id_i == n_id_sum)
    ) else $error("n_id_o differs from 3 * n_id_1_o + n_id_2");

    n_id_1_in_range: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        n_id_1_i < N_ID_1_W'(N_ID_1_SEARCH)
    ) else $error("n_id_1_o outside the searched range");

endmodule

bind sss_detector sss_detector_assert #(
    .N_ID_1_SEARCH(N_ID_1_SEARCH)
) u_assert (
    .clk_i(clk_i),
    .reset_ni(reset_ni),
    .best_i(best),
    .n_id_1_i(n_id_1_o),
    .n_id_i(n_id_o),
    .n_id_valid_i(n_id_valid_o)
);

`default_nettype wire

/* tb_sss_detector.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_sss_detector;

    import nr_sync_pkg::*;

    // a full search is 336 x 128 cycles plus table fill
    localparam int RESULT_TIMEOUT = 60000;
    localparam int BUSY_TIMEOUT = 200;
    localparam int NOISE_FLIPS = 20;

    logic clk_i;
    logic reset_ni;
    logic sss_bit_i;
    logic sss_bit_valid_i;
    logic [N_ID_2_W-1:0] n_id_2_i;
    logic n_id_2_valid_i;
    logic [N_ID_1_W-1:0] n_id_1_o;
    logic [N_ID_W-1:0] n_id_o;
    logic n_id_valid_o;

    logic [31:0] lfsr_q;

    sss_detector #(
        .N_ID_1_SEARCH(N_ID_1_COUNT)
    ) u_dut (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .sss_bit_i(sss_bit_i),
        .sss_bit_valid_i(sss_bit_valid_i),
        .n_id_2_i(n_id_2_i),
        .n_id_2_valid_i(n_id_2_valid_i),
        .n_id_1_o(n_id_1_o),
        .n_id_o(n_id_o),
        .n_id_valid_o(n_id_valid_o)
    );

    always begin
        #5 clk_i = ~clk_i;
    end

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value = (value << 1) | int'(lfsr_q[0]);
        end
    endtask

    // reference SSS, bit is 1 where the chip d(n) is +1
    task automatic make_sss(input int nid1, input int nid2, output logic [SSS_LEN-1:0] sss);
        logic [SSS_LEN-1:0] x0;
        logic [SSS_LEN-1:0] x1;
        int m0;
        int m1;
        x0 = '0;
        x1 = '0;
        x0[0] = 1'b1;
        x1[0] = 1'b1;
        for (int i = 0; i < SSS_LEN - 7; i++) begin
            x0[i + 7] = x0[i + 4] ^ x0[i];
            x1[i + 7] = x1[i + 1] ^ x1[i];
        end
        m0 = 15 * (nid1 / 112) + 5 * nid2;
        m1 = nid1 % 112;
        for (int n = 0; n < SSS_LEN; n++) begin
            sss[n] = (x0[(n + m0) % SSS_LEN] == x1[(n + m1) % SSS_LEN]);
        end
    endtask

    // flip distinct positions picked from the LFSR
    task automatic add_noise(inout logic [SSS_LEN-1:0] bits, input int flips);
        logic [SSS_LEN-1:0] used;
        int pos;
        int flipped;
        used = '0;
        flipped = 0;
        while (flipped < flips) begin
            take_random(IDX_W, pos);
            if (pos < SSS_LEN && !used[pos]) begin
                used[pos] = 1'b1;
                bits[pos] = ~bits[pos];
                flipped++;
            end
        end
    endtask

    // sector strobe, then count bits in order of index
    task automatic send_bits(input logic [SSS_LEN-1:0] bits, input int nid2, input int count);
        @(posedge clk_i);
        n_id_2_i <= N_ID_2_W'(nid2);
        n_id_2_valid_i <= 1'b1;
        for (int n = 0; n < count; n++) begin
            @(posedge clk_i);
            n_id_2_valid_i <= 1'b0;
            sss_bit_i <= bits[n];
            sss_bit_valid_i <= 1'b1;
        end
        @(posedge clk_i);
        n_id_2_valid_i <= 1'b0;
        sss_bit_valid_i <= 1'b0;
    endtask

    task automatic wait_busy(input string name);
        int waited;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > BUSY_TIMEOUT) begin
                $display("detector did not start searching in %s", name);
                $display("TEST FAIL");
                $fatal(1, "busy wait timed out");
            end
        end while (!u_dut.busy);
    endtask

    task automatic expect_result(input string name, input int nid1, input int nid2);
        int waited;
        int exp_nid;
        exp_nid = 3 * nid1 + nid2;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > RESULT_TIMEOUT) begin
                $display("no n_id_valid_o pulse within %0d cycles in %s", RESULT_TIMEOUT, name);
                $display("TEST FAIL");
                $fatal(1, "result wait timed out");
            end
        end while (!n_id_valid_o);
        assert (n_id_1_o == N_ID_1_W'(nid1)) else begin
            $display("CHECK FAILED: %s n_id_1 expected %0d actual %0d", name, nid1, n_id_1_o);
            $display("TEST FAIL");
            $fatal(1, "n_id_1 mismatch");
        end
        assert (n_id_o == N_ID_W'(exp_nid)) else begin
            $display("CHECK FAILED: %s n_id expected %0d actual %0d", name, exp_nid, n_id_o);
            $display("TEST FAIL");
            $fatal(1, "n_id mismatch");
        end
    endtask

    initial begin
        logic [SSS_LEN-1:0] frame;
        logic [SSS_LEN-1:0] junk;
        clk_i = 1'b0;
        reset_ni = 1'b0;
        sss_bit_i = 1'b0;
        sss_bit_valid_i = 1'b0;
        n_id_2_i = '0;
        n_id_2_valid_i = 1'b0;
        lfsr_q = 32'd67437;
        repeat (2) @(posedge clk_i);
        reset_ni <= 1'b1;

        make_sss(0, 0, frame);
        send_bits(frame, 0, SSS_LEN);
        expect_result("clean_0_0", 0, 0);

        // group edges and the last hypothesis
        make_sss(111, 1, frame);
        send_bits(frame, 1, SSS_LEN);
        expect_result("group0_last", 111, 1);
        make_sss(112, 2, frame);
        send_bits(frame, 2, SSS_LEN);
        expect_result("group1_first", 112, 2);
        make_sss(335, 0, frame);
        send_bits(frame, 0, SSS_LEN);
        expect_result("last_hypothesis", 335, 0);

        make_sss(200, 2, frame);
        add_noise(frame, NOISE_FLIPS);
        send_bits(frame, 2, SSS_LEN);
        expect_result("noisy", 200, 2);

        // sign flip of every chip keeps the magnitude
        make_sss(57, 1, frame);
        send_bits(~frame, 1, SSS_LEN);
        expect_result("inverted", 57, 1);

        // a second frame during the search is dropped
        make_sss(150, 0, frame);
        send_bits(frame, 0, SSS_LEN);
        wait_busy("busy_drop");
        make_sss(20, 2, junk);
        send_bits(junk, 2, SSS_LEN);
        expect_result("busy_drop", 150, 0);
        make_sss(260, 1, frame);
        send_bits(frame, 1, SSS_LEN);
        expect_result("after_busy", 260, 1);

        // reset part way into a capture
        make_sss(90, 2, frame);
        send_bits(frame, 2, 60);
        @(posedge clk_i);
        reset_ni <= 1'b0;
        repeat (2) @(posedge clk_i);
        reset_ni <= 1'b1;
        make_sss(301, 1, frame);
        send_bits(frame, 1, SSS_LEN);
        expect_result("after_reset", 301, 1);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
nr_sync_pkg.sv
sss_types_pkg.sv
mseq_lfsr.sv
sss_capture.sv
sss_correlator.sv
nid_report.sv
sss_detector.sv
sss_detector_assert.sv
tb_sss_detector.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sss_detector \
    -f build.f \
    -o sim_sss_detector

./obj_dir/sim_sss_detector
